/* verilog/radio_ctrl_pkg.sv */
package radio_ctrl_pkg;

  // Width of one response word returned to the host
  localparam int RESP_W = 40;

  // Transmit configuration register address
  localparam logic [5:0] CMD_ADDR_TXCFG = 6'h09;

  // Bit positions inside the configuration command data
  localparam int CFG_VNA_BIT   = 23;
  localparam int CFG_PA_BIT    = 19;
  localparam int CFG_TRDIS_BIT = 18;

  // One host command, strobed by cmd_valid
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        ptt;
    logic        needs_resp;
  } cmd_t;

  // Transmit configuration held between commands
  typedef struct packed {
    logic vna;
    logic pa_enable;
    logic tr_disable;
  } tx_cfg_t;

  // Telemetry values sampled into the rotating slots
  typedef struct packed {
    logic [11:0] fwd_pwr;
    logic [11:0] rev_pwr;
    logic [11:0] bias_current;
    logic [11:0] temperature;
    logic [7:0]  dsiq_status;
  } telem_t;

  // PA, T/R and RF switch enables
  typedef struct packed {
    logic env_bias;
    logic env_op;
    logic env_pa;
    logic int_tr;
    logic ext_tr;
    logic rfsw_sel;
  } rf_ctrl_t;

  typedef enum logic {
    RESP_IDLE    = 1'b0,
    RESP_PENDING = 1'b1
  } resp_state_e;

  typedef enum logic [1:0] {
    FLASH_CLR   = 2'b00,
    FLASH_SET   = 2'b01,
    FLASH_WAIT1 = 2'b10,
    FLASH_WAIT2 = 2'b11
  } flash_state_e;

endpackage

/* verilog/tx_cfg_regs.sv */
`timescale 1ns/1ps

module tx_cfg_regs (
  input  logic                    clk,
  input  logic                    arst_n_i,
  input  logic                    cmd_valid_i,
  input  radio_ctrl_pkg::cmd_t    cmd_i,
  output radio_ctrl_pkg::tx_cfg_t cfg_o,
  output logic                    host_ptt_o
);

  radio_ctrl_pkg::tx_cfg_t cfg_q;
  logic                    ptt_q;
  logic                    cfg_hit;

  // Only the configuration address touches the transmit settings
  assign cfg_hit = cmd_valid_i && (cmd_i.addr == radio_ctrl_pkg::CMD_ADDR_TXCFG);

  // Every command carries a PTT bit, whatever its address
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptt_q <= 1'b0;
    end else if (cmd_valid_i) begin
      ptt_q <= cmd_i.ptt;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_hit) begin
      // VNA mode overrides the PA path
      cfg_q.vna        <= cmd_i.data[radio_ctrl_pkg::CFG_VNA_BIT];
      cfg_q.pa_enable  <= cmd_i.data[radio_ctrl_pkg::CFG_PA_BIT];
      cfg_q.tr_disable <= cmd_i.data[radio_ctrl_pkg::CFG_TRDIS_BIT];
    end
  end

  assign cfg_o      = cfg_q;
  assign host_ptt_o = ptt_q;

endmodule

/* verilog/debounce.sv */
`timescale 1ns/1ps

module debounce #(
  parameter int DEBOUNCE_CYCLES = 16250
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic pin_n_i,
  output logic clean_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [1:0]       sync_n;
  logic [CNT_W-1:0] cnt;
  logic             clean_q;
  logic             pending;

  // Pin idles high, so the synchronizer resets to the inactive level
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_n <= 2'b11;
    end else begin
      sync_n <= {sync_n[0], pin_n_i};
    end
  end

  // Synchronized level disagrees with the debounced output
  assign pending = (~sync_n[1]) != clean_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt     <= '0;
      clean_q <= 1'b0;
    end else if (!pending) begin
      cnt <= '0;
    end else if (cnt == CNT_W'(DEBOUNCE_CYCLES)) begin
      cnt     <= '0;
      clean_q <= ~sync_n[1];
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign clean_o = clean_q;

endmodule

/* verilog/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
  parameter int MS_CYCLES   = 2500,
  parameter int LED_MS_LOG2 = 6
) (
  input  logic clk,
  input  logic arst_n_i,
  output logic led_tick_o
);

  localparam int CYC_W = $clog2(MS_CYCLES);

  logic [CYC_W-1:0]       cyc_cnt;
  logic [LED_MS_LOG2-1:0] ms_cnt;
  logic                   ms_tick;
  logic                   led_tick_q;

  // Last clock of each millisecond
  assign ms_tick = cyc_cnt == CYC_W'(MS_CYCLES - 1);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_cnt    <= '0;
      ms_cnt     <= '0;
      led_tick_q <= 1'b0;
    end else if (ms_tick) begin
      cyc_cnt    <= '0;
      ms_cnt     <= ms_cnt + 1'b1;
      // Fires as the millisecond count wraps
      led_tick_q <= &ms_cnt;
    end else begin
      cyc_cnt    <= cyc_cnt + 1'b1;
      led_tick_q <= 1'b0;
    end
  end

  assign led_tick_o = led_tick_q;

endmodule

/* verilog/led_flash.sv */
`timescale 1ns/1ps

module led_flash (
  input  logic clk,
  input  logic arst_n_i,
  input  logic tick_i,
  input  logic event_i,
  output logic led_n_o
);

  radio_ctrl_pkg::flash_state_e state;
  radio_ctrl_pkg::flash_state_e state_d;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= radio_ctrl_pkg::FLASH_CLR;
    end else begin
      state <= state_d;
    end
  end

  // First tick may come right after the event, hence two to three ticks lit
  always_comb begin
    state_d = state;
    case (state)
      radio_ctrl_pkg::FLASH_CLR: begin
        if (event_i) state_d = radio_ctrl_pkg::FLASH_SET;
      end
      radio_ctrl_pkg::FLASH_SET: begin
        if (tick_i) state_d = radio_ctrl_pkg::FLASH_WAIT1;
      end
      radio_ctrl_pkg::FLASH_WAIT1: begin
        if (tick_i) state_d = radio_ctrl_pkg::FLASH_WAIT2;
      end
      radio_ctrl_pkg::FLASH_WAIT2: begin
        if (tick_i) state_d = radio_ctrl_pkg::FLASH_CLR;
      end
      default: begin
        state_d = radio_ctrl_pkg::FLASH_CLR;
      end
    endcase
  end

  // Active-low LED, dark only when idle
  assign led_n_o = state == radio_ctrl_pkg::FLASH_CLR;

endmodule

/* verilog/tx_switch.sv */
`timescale 1ns/1ps

module tx_switch (
  input  logic                     run_i,
  input  logic                     host_ptt_i,
  input  logic                     ext_ptt_i,
  input  logic                     ext_inhibit_i,
  input  radio_ctrl_pkg::tx_cfg_t  cfg_i,
  output logic                     tx_on_o,
  output radio_ctrl_pkg::rf_ctrl_t rf_ctrl_o
);

  logic tx_on;
  logic pa_path;

  // Any PTT source keys the radio unless inhibited or stopped
  assign tx_on = (host_ptt_i || ext_ptt_i) && !ext_inhibit_i && run_i;

  // PA is in circuit only outside VNA mode
  assign pa_path = !cfg_i.vna && cfg_i.pa_enable;

  always_comb begin
    rf_ctrl_o.env_op   = tx_on;
    rf_ctrl_o.ext_tr   = tx_on;
    rf_ctrl_o.env_pa   = tx_on && pa_path;
    rf_ctrl_o.env_bias = tx_on && pa_path;
    // Internal T/R relay also follows PTT when T/R is not disabled
    rf_ctrl_o.int_tr   = tx_on && !cfg_i.vna && (cfg_i.pa_enable || !cfg_i.tr_disable);
    rf_ctrl_o.rfsw_sel = pa_path;
  end

  assign tx_on_o = tx_on;

endmodule

/* verilog/resp_builder.sv */
`timescale 1ns/1ps

module resp_builder #(
  parameter logic [7:0] SERIAL_NO = 8'h00
) (
  input  logic                                clk,
  input  logic                                arst_n_i,
  input  logic                                cmd_valid_i,
  input  radio_ctrl_pkg::cmd_t                cmd_i,
  input  logic                                resp_rqst_i,
  input  logic                                tx_on_i,
  input  logic                                key_i,
  input  logic                                ext_ptt_i,
  input  logic                                rxclip_i,
  input  radio_ctrl_pkg::telem_t              telem_i,
  output logic [radio_ctrl_pkg::RESP_W-1:0]   resp_o
);

  radio_ctrl_pkg::resp_state_e state;
  radio_ctrl_pkg::resp_state_e state_d;

  logic [5:0]                        echo_addr;
  logic [31:0]                       echo_data;
  logic [1:0]                        slot;
  logic [1:0]                        clip_cnt;
  logic                              capture;
  logic [7:0]                        telem_hdr;
  logic [31:0]                       telem_data;
  logic [radio_ctrl_pkg::RESP_W-1:0] resp_q;

  assign capture = cmd_valid_i && cmd_i.needs_resp;

  // Queue depth is one, a newer command replaces the older echo
  always_comb begin
    state_d = state;
    case (state)
      radio_ctrl_pkg::RESP_IDLE: begin
        if (capture) state_d = radio_ctrl_pkg::RESP_PENDING;
      end
      radio_ctrl_pkg::RESP_PENDING: begin
        if (resp_rqst_i && !capture) state_d = radio_ctrl_pkg::RESP_IDLE;
      end
      default: begin
        state_d = radio_ctrl_pkg::RESP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= radio_ctrl_pkg::RESP_IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      echo_addr <= '0;
      echo_data <= '0;
    end else if (capture) begin
      echo_addr <= cmd_i.addr;
      echo_data <= cmd_i.data;
    end
  end

  // Common header of every telemetry word
  assign telem_hdr = {3'b000, slot, key_i, 1'b0, ext_ptt_i};

  always_comb begin
    case (slot)
      2'd0: telem_data = {7'b0001111, &clip_cnt, 8'h00, telem_i.dsiq_status, SERIAL_NO};
      2'd1: telem_data = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      2'd2: telem_data = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      default: telem_data = 32'h0000_0000;
    endcase
  end

  // Slot advances even when an echo takes its place
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_q   <= '0;
      slot     <= 2'd0;
      clip_cnt <= 2'd0;
    end else if (resp_rqst_i) begin
      slot     <= slot + 2'd1;
      clip_cnt <= 2'd0;
      if (state == radio_ctrl_pkg::RESP_PENDING) begin
        resp_q <= {1'b1, echo_addr, tx_on_i, echo_data};
      end else begin
        resp_q <= {telem_hdr, telem_data};
      end
    end else if (!(&clip_cnt)) begin
      // Saturates at three clipped cycles
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  assign resp_o = resp_q;

endmodule

/* verilog/radio_ctrl.sv */
`timescale 1ns/1ps

module radio_ctrl #(
  parameter logic [7:0] SERIAL_NO       = 8'h00,
  parameter int         MS_CYCLES       = 2500,
  parameter int         LED_MS_LOG2     = 6,
  parameter int         DEBOUNCE_CYCLES = 16250
) (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic                              run_i,
  input  logic                              cmd_valid_i,
  input  radio_ctrl_pkg::cmd_t              cmd_i,
  input  logic                              resp_rqst_i,
  output logic [radio_ctrl_pkg::RESP_W-1:0] resp_o,
  input  radio_ctrl_pkg::telem_t            telem_i,
  input  logic                              rxclip_i,
  input  logic                              rxgood_i,
  input  logic                              ptt_n_i,
  input  logic                              key_n_i,
  input  logic                              inhibit_n_i,
  output logic                              tx_on_o,
  output radio_ctrl_pkg::rf_ctrl_t          rf_ctrl_o,
  output logic                              led_clip_n_o,
  output logic                              led_good_n_o,
  output logic                              led_tx_n_o
);

  radio_ctrl_pkg::tx_cfg_t cfg;
  logic                    host_ptt;
  logic                    ext_ptt;
  logic                    ext_key;
  logic                    ext_inhibit;
  logic                    led_tick;

  tx_cfg_regs u_cfg (
    .clk(clk), .arst_n_i(arst_n_i), .cmd_valid_i(cmd_valid_i),
    .cmd_i(cmd_i), .cfg_o(cfg), .host_ptt_o(host_ptt)
  );

  // Front-panel inputs
  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_ptt (
    .clk(clk), .arst_n_i(arst_n_i), .pin_n_i(ptt_n_i), .clean_o(ext_ptt)
  );
  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_key (
    .clk(clk), .arst_n_i(arst_n_i), .pin_n_i(key_n_i), .clean_o(ext_key)
  );
  debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_inh (
    .clk(clk), .arst_n_i(arst_n_i), .pin_n_i(inhibit_n_i), .clean_o(ext_inhibit)
  );

  tick_gen #(.MS_CYCLES(MS_CYCLES), .LED_MS_LOG2(LED_MS_LOG2)) u_tick (
    .clk(clk), .arst_n_i(arst_n_i), .led_tick_o(led_tick)
  );

  // Receive status LEDs
  led_flash u_flash_clip (
    .clk(clk), .arst_n_i(arst_n_i), .tick_i(led_tick),
    .event_i(rxclip_i), .led_n_o(led_clip_n_o)
  );
  led_flash u_flash_good (
    .clk(clk), .arst_n_i(arst_n_i), .tick_i(led_tick),
    .event_i(rxgood_i), .led_n_o(led_good_n_o)
  );

  tx_switch u_tx_sw (
    .run_i(run_i), .host_ptt_i(host_ptt), .ext_ptt_i(ext_ptt),
    .ext_inhibit_i(ext_inhibit), .cfg_i(cfg),
    .tx_on_o(tx_on_o), .rf_ctrl_o(rf_ctrl_o)
  );

  resp_builder #(.SERIAL_NO(SERIAL_NO)) u_resp (
    .clk(clk), .arst_n_i(arst_n_i), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
    .resp_rqst_i(resp_rqst_i), .tx_on_i(tx_on_o), .key_i(ext_key),
    .ext_ptt_i(ext_ptt), .rxclip_i(rxclip_i), .telem_i(telem_i), .resp_o(resp_o)
  );

  assign led_tx_n_o = ~tx_on_o;

endmodule

/* test/radio_ctrl_properties.sv */
`timescale 1ns/1ps

module radio_ctrl_properties (
  input logic                        clk,
  input logic                        arst_n_i,
  input logic                        run_i,
  input logic                        cmd_valid_i,
  input radio_ctrl_pkg::cmd_t        cmd_i,
  input logic                        tx_on_o,
  input radio_ctrl_pkg::rf_ctrl_t    rf_ctrl_o,
  input radio_ctrl_pkg::resp_state_e resp_state
);

  // The RF switch follows the configuration alone, so it is left out here
  a_rf_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    !tx_on_o |-> ({rf_ctrl_o.env_bias, rf_ctrl_o.env_op, rf_ctrl_o.env_pa,
                   rf_ctrl_o.int_tr, rf_ctrl_o.ext_tr} == 5'b0))
    else $error("RF enable active while transmitter is off");

  a_tx_run: assert property (@(posedge clk) disable iff (!arst_n_i)
    tx_on_o |-> run_i)
    else $error("Transmitter on without run");

  // A command asking for an echo always leaves one pending
  a_resp_pending: assert property (@(posedge clk) disable iff (!arst_n_i)
    cmd_valid_i && cmd_i.needs_resp |=> resp_state == radio_ctrl_pkg::RESP_PENDING)
    else $error("Echo request not held pending");

endmodule

bind radio_ctrl radio_ctrl_properties u_props (
  .clk(clk), .arst_n_i(arst_n_i), .run_i(run_i), .cmd_valid_i(cmd_valid_i),
  .cmd_i(cmd_i), .tx_on_o(tx_on_o), .rf_ctrl_o(rf_ctrl_o), .resp_state(u_resp.state)
);

/* test/radio_ctrl_tb.sv */
`timescale 1ns/1ps

module radio_ctrl_tb;

  localparam logic [7:0] SERIAL_NO       = 8'hA5;
  localparam int         MS_CYCLES       = 4;
  localparam int         LED_MS_LOG2     = 2;
  localparam int         DEBOUNCE_CYCLES = 3;
  localparam int         LED_PERIOD      = MS_CYCLES << LED_MS_LOG2;
  localparam int         N_STEPS         = 30;
  localparam logic [5:0] OTHER_ADDR      = 6'h12;
  localparam logic [5:0] CFG_ADDR        = radio_ctrl_pkg::CMD_ADDR_TXCFG;

  typedef enum logic [2:0] {A_CMD, A_RQST, A_PIN, A_RUN, A_GLITCH, A_TELEM, A_LED} act_e;

  typedef struct {
    string      name;
    act_e       act;
    logic [5:0] addr;
    logic [2:0] cfg;
    logic       ptt;
    logic       needs_resp;
    logic [7:0] arg;
    logic       exp_tx;
  } step_t;

  logic clk, arst_n_i, run_i, cmd_valid_i, resp_rqst_i, rxclip_i, rxgood_i;
  logic ptt_n_i, key_n_i, inhibit_n_i, tx_on_o, led_clip_n_o, led_good_n_o, led_tx_n_o;
  logic [radio_ctrl_pkg::RESP_W-1:0] resp_o;
  radio_ctrl_pkg::cmd_t              cmd_i;
  radio_ctrl_pkg::telem_t            telem_i;
  radio_ctrl_pkg::rf_ctrl_t          rf_ctrl_o;

  step_t       steps [0:N_STEPS-1];
  logic [31:0] lfsr = 32'h823b129a;

  // Reference model state
  radio_ctrl_pkg::tx_cfg_t m_cfg;
  logic        m_ext_ptt, m_key, m_pending;
  logic [5:0]  m_echo_addr;
  logic [31:0] m_echo_data;
  logic [1:0]  m_slot;
  int          m_clip;

  radio_ctrl #(.SERIAL_NO(SERIAL_NO), .MS_CYCLES(MS_CYCLES), .LED_MS_LOG2(LED_MS_LOG2),
               .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) dut (.*);

  always #2 clk = ~clk;

  // Galois LFSR, one shift per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic step_t mk(input string nm, input act_e act, input logic [5:0] addr,
                               input logic [2:0] cfg, input logic ptt, input logic nr,
                               input logic [7:0] arg, input logic exp_tx);
    step_t s;
    s.name = nm;
    s.act = act;
    s.addr = addr;
    s.cfg = cfg;
    s.ptt = ptt;
    s.needs_resp = nr;
    s.arg = arg;
    s.exp_tx = exp_tx;
    return s;
  endfunction

  function automatic radio_ctrl_pkg::rf_ctrl_t rf_rule(input radio_ctrl_pkg::tx_cfg_t c,
                                                        input logic tx);
    radio_ctrl_pkg::rf_ctrl_t r;
    r.env_op   = tx;
    r.ext_tr   = tx;
    r.env_pa   = tx && !c.vna && c.pa_enable;
    r.env_bias = tx && !c.vna && c.pa_enable;
    r.int_tr   = tx && !c.vna && (c.pa_enable || !c.tr_disable);
    r.rfsw_sel = !c.vna && c.pa_enable;
    return r;
  endfunction

  function automatic logic [radio_ctrl_pkg::RESP_W-1:0] expected_resp(input logic tx);
    logic [31:0] d;
    if (m_pending) return {1'b1, m_echo_addr, tx, m_echo_data};
    case (m_slot)
      2'd0: d = {7'b0001111, m_clip >= 3, 8'h00, telem_i.dsiq_status, SERIAL_NO};
      2'd1: d = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      2'd2: d = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      default: d = '0;
    endcase
    return {3'b000, m_slot, m_key, 1'b0, m_ext_ptt, d};
  endfunction

  task automatic check_resp(input step_t s, input logic [radio_ctrl_pkg::RESP_W-1:0] exp,
                            input logic [radio_ctrl_pkg::RESP_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %0s expected %h actual %h", s.name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_rf(input step_t s, input radio_ctrl_pkg::rf_ctrl_t exp,
                          input radio_ctrl_pkg::rf_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0s expected %b actual %b", s.name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input step_t s, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0s expected %b actual %b", s.name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_tx(input step_t s);
    check_bit(s, s.exp_tx, tx_on_o);
    check_bit(s, !s.exp_tx, led_tx_n_o);
    check_rf(s, rf_rule(m_cfg, s.exp_tx), rf_ctrl_o);
  endtask

  initial begin
    repeat (N_STEPS * 64) @(posedge clk);
    $display("Timeout, the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  initial begin
    step_t                  st;
    logic [31:0]            d;
    radio_ctrl_pkg::telem_t tel;
    int                     cnt;
    int                     cnt_good;
    clk = 0;
    arst_n_i = 0;
    run_i = 1;
    cmd_valid_i = 0;
    cmd_i = '0;
    resp_rqst_i = 0;
    telem_i = '0;
    rxclip_i = 0;
    rxgood_i = 0;
    ptt_n_i = 1;
    key_n_i = 1;
    inhibit_n_i = 1;
    m_cfg = '0;
    m_ext_ptt = 0;
    m_key = 0;
    m_pending = 0;
    m_slot = 0;
    m_clip = 0;
    m_echo_addr = '0;
    m_echo_data = '0;
    for (int c = 0; c < 8; c++) begin
      steps[c] = mk($sformatf("cfg_%0d", c), A_CMD, CFG_ADDR, c, 1, 0, 0, 1);
    end
    steps[8]  = mk("other_addr", A_CMD, OTHER_ADDR, 3'b000, 1, 0, 0, 1);
    steps[9]  = mk("host_off", A_CMD, CFG_ADDR, 3'b010, 0, 0, 0, 0);
    steps[10] = mk("pin_ptt", A_PIN, 0, 0, 0, 0, 8'd1, 1);
    steps[11] = mk("pin_inhibit", A_PIN, 0, 0, 0, 0, 8'd3, 0);
    steps[12] = mk("pin_key", A_PIN, 0, 0, 0, 0, 8'd4, 0);
    steps[13] = mk("host_on", A_CMD, CFG_ADDR, 3'b010, 1, 0, 0, 1);
    steps[14] = mk("run_low", A_RUN, 0, 0, 0, 0, 8'd0, 0);
    steps[15] = mk("run_high", A_RUN, 0, 0, 0, 0, 8'd1, 1);
    steps[16] = mk("host_off2", A_CMD, CFG_ADDR, 3'b010, 0, 0, 0, 0);
    steps[17] = mk("glitch", A_GLITCH, 0, 0, 0, 0, DEBOUNCE_CYCLES - 1, 0);
    steps[18] = mk("echo_cmd", A_CMD, OTHER_ADDR, 3'b000, 0, 1, 0, 0);
    for (int i = 19; i < 23; i++) begin
      steps[i] = mk($sformatf("rqst_%0d", i), A_RQST, 0, 0, 0, 0, 0, 0);
    end
    steps[23] = mk("telem_clip", A_TELEM, 0, 0, 0, 0, 8'd4, 0);
    for (int i = 24; i < 29; i++) begin
      steps[i] = mk($sformatf("rqst_%0d", i), A_RQST, 0, 0, 0, 0, 0, 0);
    end
    steps[29] = mk("led_stretch", A_LED, 0, 0, 0, 0, 0, 0);
    repeat (5) @(posedge clk);
    arst_n_i <= 1;
    for (int i = 0; i < N_STEPS; i++) begin
      st = steps[i];
      case (st.act)
        A_CMD: begin
          d = rand_bits(32);
          d[radio_ctrl_pkg::CFG_VNA_BIT]   = st.cfg[2];
          d[radio_ctrl_pkg::CFG_PA_BIT]    = st.cfg[1];
          d[radio_ctrl_pkg::CFG_TRDIS_BIT] = st.cfg[0];
          @(posedge clk);
          cmd_valid_i <= 1;
          cmd_i <= '{addr: st.addr, data: d, ptt: st.ptt, needs_resp: st.needs_resp};
          @(posedge clk);
          cmd_valid_i <= 0;
          if (st.addr == CFG_ADDR) begin
            m_cfg = '{vna: st.cfg[2], pa_enable: st.cfg[1], tr_disable: st.cfg[0]};
          end
          if (st.needs_resp) begin
            m_pending = 1;
            m_echo_addr = st.addr;
            m_echo_data = d;
          end
          @(negedge clk);
          check_tx(st);
        end
        A_RQST: begin
          @(posedge clk);
          resp_rqst_i <= 1;
          @(posedge clk);
          resp_rqst_i <= 0;
          @(negedge clk);
          check_resp(st, expected_resp(st.exp_tx), resp_o);
          m_pending = 0;
          m_slot = m_slot + 1;
          m_clip = 0;
        end
        A_PIN: begin
          @(posedge clk);
          ptt_n_i <= !st.arg[0];
          inhibit_n_i <= !st.arg[1];
          key_n_i <= !st.arg[2];
          m_ext_ptt = st.arg[0];
          m_key = st.arg[2];
          // Two synchronizer flops, the count and the output flop, plus margin
          repeat (DEBOUNCE_CYCLES + 6) @(posedge clk);
          @(negedge clk);
          check_tx(st);
        end
        A_RUN: begin
          @(posedge clk);
          run_i <= st.arg[0];
          @(negedge clk);
          check_tx(st);
        end
        A_GLITCH: begin
          @(posedge clk);
          ptt_n_i <= 0;
          repeat (st.arg) @(posedge clk);
          ptt_n_i <= 1;
          repeat (DEBOUNCE_CYCLES + 8) begin
            @(negedge clk);
            check_tx(st);
          end
        end
        A_TELEM: begin
          tel[55:32] = 24'(rand_bits(24));
          tel[31:0]  = rand_bits(32);
          @(posedge clk);
          telem_i <= tel;
          rxclip_i <= 1;
          repeat (st.arg) @(posedge clk);
          rxclip_i <= 0;
          m_clip = (m_clip + st.arg > 3) ? 3 : m_clip + st.arg;
        end
        default: begin
          cnt = 0;
          while (led_clip_n_o !== 1'b1 && cnt < 4 * LED_PERIOD) begin
            @(negedge clk);
            cnt++;
          end
          check_bit(st, 1'b1, led_clip_n_o);
          check_bit(st, 1'b1, led_good_n_o);
          @(posedge clk);
          rxclip_i <= 1;
          rxgood_i <= 1;
          @(posedge clk);
          rxclip_i <= 0;
          rxgood_i <= 0;
          cnt = 0;
          cnt_good = 0;
          repeat (4 * LED_PERIOD) begin
            @(negedge clk);
            if (!led_clip_n_o) cnt++;
            if (!led_good_n_o) cnt_good++;
          end
          check_bit(st, 1'b1, cnt >= 2 * LED_PERIOD);
          check_bit(st, 1'b1, cnt_good >= 2 * LED_PERIOD);
          check_bit(st, 1'b1, led_clip_n_o);
          check_bit(st, 1'b1, led_good_n_o);
        end
      endcase
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* list.f */
verilog/radio_ctrl_pkg.sv
verilog/tx_cfg_regs.sv
verilog/debounce.sv
verilog/tick_gen.sv
verilog/led_flash.sv
verilog/tx_switch.sv
verilog/resp_builder.sv
verilog/radio_ctrl.sv
test/radio_ctrl_properties.sv
test/radio_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wall -Wno-fatal \
  -f list.f \
  --top-module radio_ctrl_tb \
  -o radio_ctrl_sim
./obj_dir/radio_ctrl_sim
